// ==== design/io_pkg.sv ====
/*
 * I/O register block definitions
 * Bus types, register map, output widths and status bit layout
 */
package io_pkg;

	typedef logic [31:0] io_addr_t;	// Byte address on the strobe bus
	typedef logic [31:0] io_data_t;	// Read and write data word

	// Register map, word aligned
	localparam io_addr_t addr_red_led = 32'd0;
	localparam io_addr_t addr_green_led = 32'd4;
	localparam io_addr_t addr_hex0 = 32'd8;
	localparam io_addr_t addr_hex1 = 32'd12;
	localparam io_addr_t addr_hex2 = 32'd16;
	localparam io_addr_t addr_hex3 = 32'd20;
	localparam io_addr_t addr_uart_status = 32'd24;	// Read clears overrun
	localparam io_addr_t addr_uart_rx_data = 32'd28;	// Read pops FIFO
	localparam io_addr_t addr_uart_tx_data = 32'd32;	// Write starts a frame
	localparam io_addr_t addr_timer = 32'd36;	// Free-running cycle count

	localparam int red_led_width = 18;
	localparam int green_led_width = 9;
	localparam int hex_width = 7;	// One segment per bit

	typedef logic [red_led_width-1:0] red_led_t;
	typedef logic [green_led_width-1:0] green_led_t;
	typedef logic [hex_width-1:0] hex_t;

	// UART status word bit positions
	localparam int status_rx_avail = 0;
	localparam int status_tx_busy = 1;
	localparam int status_overrun = 2;

endpackage

// ==== design/uart_pkg.sv ====
/*
 * UART definitions
 * Bit timing, receive FIFO sizing and FSM state encodings
 */
package uart_pkg;

	typedef logic [7:0] uart_byte_t;	// One data byte, sent LSB first

	localparam int baud_divide = 27;	// Core clocks per bit
	localparam int baud_half = baud_divide / 2;	// Start bit middle
	typedef logic [$clog2(baud_divide)-1:0] baud_count_t;

	localparam int fifo_depth = 8;
	typedef logic [3:0] fifo_count_t;	// Holds 0 to fifo_depth
	typedef logic [$clog2(fifo_depth)-1:0] fifo_ptr_t;

	typedef enum logic [1:0] {
		tx_state_idle,
		tx_state_start,
		tx_state_data,
		tx_state_stop
	} tx_state_t;

	typedef enum logic [1:0] {
		rx_state_idle,
		rx_state_start,
		rx_state_data,
		rx_state_stop
	} rx_state_t;

endpackage

// ==== design/uart_if.sv ====
/*
 * UART side channel of the register block
 * Transmit request, receive FIFO head and overrun handshake
 */
interface uart_if;
	import uart_pkg::*;

	logic tx_start;	// One-cycle strobe, only when idle
	uart_byte_t tx_data;	// Valid with tx_start
	logic tx_busy;	// Frame in progress
	uart_byte_t rx_data;	// Oldest byte in FIFO
	logic rx_avail;	// FIFO not empty
	logic rx_pop;	// Consume rx_data
	logic overrun_clear;	// Status read
	logic overrun;	// Byte lost on full FIFO

	modport regs(
		output tx_start, tx_data, rx_pop, overrun_clear,
		input tx_busy, rx_data, rx_avail, overrun
	);

	modport tx(input tx_start, tx_data, output tx_busy);

	modport rxq(input rx_pop, overrun_clear, output rx_data, rx_avail, overrun);

endinterface

// ==== design/uart_transmit.sv ====
/*
 * UART transmitter
 * Sends one start bit, eight data bits LSB first and one stop bit
 */
module uart_transmit(
	input logic core_clk,
	input logic core_reset,
	uart_if.tx bus,
	output logic uart_tx);

	import uart_pkg::*;

	tx_state_t state;
	baud_count_t baud_count;	// Cycles within current bit
	logic [2:0] bit_count;	// Data bit being sent
	uart_byte_t shift;	// Remaining data bits
	logic baud_done;

	assign baud_done = baud_count == baud_count_t'(baud_divide - 1);
	assign bus.tx_busy = state != tx_state_idle;

	always_ff @(posedge core_clk or posedge core_reset)
	begin
		if (core_reset)
		begin
			state <= tx_state_idle;
			baud_count <= '0;
			bit_count <= '0;
			uart_tx <= 1'b1;	// Line idles high
		end
		else
		begin
			baud_count <= baud_done ? '0 : baud_count + 1'b1;
			case (state)
				tx_state_idle:
				begin
					baud_count <= '0;
					if (bus.tx_start)
					begin
						state <= tx_state_start;
						uart_tx <= 1'b0;	// Start bit on this edge
					end
				end

				tx_state_start:
					if (baud_done)
					begin
						state <= tx_state_data;
						bit_count <= '0;
						uart_tx <= shift[0];	// First data bit
					end

				tx_state_data:
					if (baud_done)
					begin
						bit_count <= bit_count + 1'b1;
						if (bit_count == 3'd7)
						begin
							state <= tx_state_stop;
							uart_tx <= 1'b1;	// Stop bit
						end
						else
							uart_tx <= shift[1];	// Next bit, shift moves this edge
					end

				tx_state_stop:
					if (baud_done)
						state <= tx_state_idle;

				default: state <= tx_state_idle;
			endcase
		end
	end

	// Data shifter
	always_ff @(posedge core_clk)
	begin
		if (state == tx_state_idle && bus.tx_start)
			shift <= bus.tx_data;	// Latch byte
		else if (state == tx_state_data && baud_done)
			shift <= shift >> 1;
	end

endmodule

// ==== design/uart_receive.sv ====
/*
 * UART receiver
 * Synchronizes the line, checks the start bit at its middle and samples
 * eight data bits at mid-bit, strobing the byte out on a good stop bit
 */
module uart_receive(
	input logic core_clk,
	input logic core_reset,
	input logic uart_rx,
	output uart_pkg::uart_byte_t rx_byte,
	output logic rx_strobe);

	import uart_pkg::*;

	logic [2:0] rx_sync;	// Two sync flops, third for edge detect
	logic rx_line;	// Synchronized line level
	logic rx_fall;
	rx_state_t state;
	baud_count_t baud_count;
	logic [2:0] bit_count;
	logic half_done;	// Middle of start bit
	logic baud_done;	// Middle of next bit

	assign rx_line = rx_sync[1];
	assign rx_fall = rx_sync[2] && !rx_sync[1];
	assign half_done = baud_count == baud_count_t'(baud_half - 1);
	assign baud_done = baud_count == baud_count_t'(baud_divide - 1);

	always_ff @(posedge core_clk or posedge core_reset)
	begin
		if (core_reset)
		begin
			rx_sync <= '1;	// Idle high, no false edge
			state <= rx_state_idle;
			baud_count <= '0;
			bit_count <= '0;
			rx_strobe <= 1'b0;
		end
		else
		begin
			rx_sync <= {rx_sync[1:0], uart_rx};
			rx_strobe <= 1'b0;
			baud_count <= baud_count + 1'b1;
			case (state)
				rx_state_idle:
				begin
					baud_count <= '0;
					if (rx_fall)
						state <= rx_state_start;
				end

				rx_state_start:
					if (half_done)
					begin
						baud_count <= '0;
						bit_count <= '0;
						if (rx_line)
							state <= rx_state_idle;	// Glitch, not a start bit
						else
							state <= rx_state_data;
					end

				rx_state_data:
					if (baud_done)
					begin
						baud_count <= '0;
						bit_count <= bit_count + 1'b1;
						if (bit_count == 3'd7)
							state <= rx_state_stop;
					end

				rx_state_stop:
					if (baud_done)
					begin
						state <= rx_state_idle;
						rx_strobe <= rx_line;	// Framing error drops byte
					end

				default: state <= rx_state_idle;
			endcase
		end
	end

	// Data bits arrive LSB first
	always_ff @(posedge core_clk)
	begin
		if (state == rx_state_data && baud_done)
			rx_byte <= {rx_line, rx_byte[7:1]};
	end

endmodule

// ==== design/uart_rx_fifo.sv ====
/*
 * UART receive FIFO
 * Eight-entry circular buffer with overrun flag on push while full
 */
module uart_rx_fifo(
	input logic core_clk,
	input logic core_reset,
	input uart_pkg::uart_byte_t rx_byte,
	input logic rx_strobe,
	uart_if.rxq bus);

	import uart_pkg::*;

	uart_byte_t mem[fifo_depth];	// Byte storage
	fifo_ptr_t wr_ptr;
	fifo_ptr_t rd_ptr;
	fifo_count_t count;	// Bytes held
	logic full;
	logic push;
	logic pop;

	assign full = count == fifo_count_t'(fifo_depth);
	assign push = rx_strobe && !full;
	assign pop = bus.rx_pop && bus.rx_avail;	// Pop on empty ignored
	assign bus.rx_avail = count != '0;
	assign bus.rx_data = mem[rd_ptr];	// Head of queue

	always_ff @(posedge core_clk or posedge core_reset)
	begin
		if (core_reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			bus.overrun <= 1'b0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;	// Wraps at depth
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;	// Both or neither
			endcase

			if (bus.overrun_clear)
				bus.overrun <= 1'b0;
			if (rx_strobe && full)
				bus.overrun <= 1'b1;	// New loss wins over clear
		end
	end

	always_ff @(posedge core_clk)
	begin
		if (push)
			mem[wr_ptr] <= rx_byte;
	end

endmodule

// ==== design/io_register_file.sv ====
/*
 * Memory-mapped I/O registers
 * Decodes the strobe bus, holds LED and hex outputs and the cycle timer,
 * and turns UART register accesses into strobes on the UART channel
 */
module io_register_file(
	input logic core_clk,
	input logic core_reset,
	input io_pkg::io_addr_t address,
	input logic write_en,
	input logic read_en,
	input io_pkg::io_data_t write_data,
	output io_pkg::io_data_t read_data,
	output io_pkg::red_led_t red_led,
	output io_pkg::green_led_t green_led,
	output io_pkg::hex_t hex0,
	output io_pkg::hex_t hex1,
	output io_pkg::hex_t hex2,
	output io_pkg::hex_t hex3,
	uart_if.regs bus);

	import io_pkg::*;
	import uart_pkg::*;

	io_data_t timer;	// Cycles since reset release
	io_data_t status;	// UART status word

	// Output registers and timer
	always_ff @(posedge core_clk or posedge core_reset)
	begin
		if (core_reset)
		begin
			red_led <= '0;
			green_led <= '0;
			hex0 <= '0;
			hex1 <= '0;
			hex2 <= '0;
			hex3 <= '0;
			timer <= '0;
		end
		else
		begin
			timer <= timer + 1'b1;	// Wraps silently

			if (write_en)
			begin
				case (address)
					addr_red_led: red_led <= write_data[red_led_width-1:0];
					addr_green_led: green_led <= write_data[green_led_width-1:0];
					addr_hex0: hex0 <= write_data[hex_width-1:0];
					addr_hex1: hex1 <= write_data[hex_width-1:0];
					addr_hex2: hex2 <= write_data[hex_width-1:0];
					addr_hex3: hex3 <= write_data[hex_width-1:0];
					default: ;	// UART and unmapped handled below
				endcase
			end
		end
	end

	// UART strobes, decoded straight off the bus
	always_comb
	begin
		bus.tx_start = write_en && (address == addr_uart_tx_data)
			&& !bus.tx_busy;	// Dropped while a frame is out
		bus.tx_data = uart_byte_t'(write_data);	// Low byte only
		bus.rx_pop = read_en && (address == addr_uart_rx_data);
		bus.overrun_clear = read_en && (address == addr_uart_status);
	end

	always_comb
	begin
		status = '0;
		status[status_rx_avail] = bus.rx_avail;
		status[status_tx_busy] = bus.tx_busy;
		status[status_overrun] = bus.overrun;
	end

	// Read mux, same cycle as address
	always_comb
	begin
		case (address)
			addr_uart_status: read_data = status;
			addr_uart_rx_data: read_data = io_data_t'(bus.rx_data);	// Zero extended
			addr_timer: read_data = timer;
			default: read_data = '0;	// LEDs are write only
		endcase
	end

endmodule

// ==== design/io_top.sv ====
/*
 * Core clock I/O subsystem
 * Strobe bus register block with LEDs, hex digits, timer and a UART
 */
module io_top(
	input logic core_clk,
	input logic core_reset,
	input io_pkg::io_addr_t address,
	input logic write_en,
	input logic read_en,
	input io_pkg::io_data_t write_data,
	output io_pkg::io_data_t read_data,
	output io_pkg::red_led_t red_led,
	output io_pkg::green_led_t green_led,
	output io_pkg::hex_t hex0,
	output io_pkg::hex_t hex1,
	output io_pkg::hex_t hex2,
	output io_pkg::hex_t hex3,
	output logic uart_tx,
	input logic uart_rx);

	import uart_pkg::*;

	uart_byte_t rx_byte;	// Receiver to FIFO
	logic rx_strobe;

	uart_if bus();

	io_register_file register_file(
		.core_clk(core_clk),
		.core_reset(core_reset),
		.address(address),
		.write_en(write_en),
		.read_en(read_en),
		.write_data(write_data),
		.read_data(read_data),
		.red_led(red_led),
		.green_led(green_led),
		.hex0(hex0),
		.hex1(hex1),
		.hex2(hex2),
		.hex3(hex3),
		.bus(bus.regs));

	uart_transmit transmit(
		.core_clk(core_clk),
		.core_reset(core_reset),
		.bus(bus.tx),
		.uart_tx(uart_tx));

	uart_receive receive(
		.core_clk(core_clk),
		.core_reset(core_reset),
		.uart_rx(uart_rx),
		.rx_byte(rx_byte),
		.rx_strobe(rx_strobe));

	uart_rx_fifo rx_fifo(
		.core_clk(core_clk),
		.core_reset(core_reset),
		.rx_byte(rx_byte),
		.rx_strobe(rx_strobe),
		.bus(bus.rxq));

endmodule

// ==== sim/io_top_tb.sv ====
/*
 * Self-checking testbench for the I/O subsystem
 * Table of bus accesses, then UART frame, loopback and overrun checks
 */
module io_top_tb;
	import io_pkg::*;
	import uart_pkg::*;

	localparam int op_write = 0;	// Write, then check that output
	localparam int op_read = 1;	// Read with side effects, compare
	localparam int op_output = 2;	// Compare one output register
	localparam int op_timer = 3;	// Two timer reads, data cycles apart
	localparam int op_ignored = 4;	// Write that must change no output
	localparam int cycle_limit = 12 * 270 + 1000;

	typedef struct packed {
		int op;
		io_addr_t addr;
		io_data_t data;
		io_data_t expected;
	} step_t;

	logic core_clk = 1'b0;
	logic core_reset = 1'b1;
	io_addr_t address = '0;
	logic write_en = 1'b0;
	logic read_en = 1'b0;
	io_data_t write_data = '0;
	io_data_t read_data;
	red_led_t red_led;
	green_led_t green_led;
	hex_t hex0;
	hex_t hex1;
	hex_t hex2;
	hex_t hex3;
	logic uart_line;	// tx looped back to rx
	step_t steps[$];
	uart_byte_t sent[$];	// Bytes still expected from the FIFO
	logic [31:0] lfsr = 32'he8ec;
	int cycles = 0;

	io_top DUT(
		.core_clk(core_clk),
		.core_reset(core_reset),
		.address(address),
		.write_en(write_en),
		.read_en(read_en),
		.write_data(write_data),
		.read_data(read_data),
		.red_led(red_led),
		.green_led(green_led),
		.hex0(hex0),
		.hex1(hex1),
		.hex2(hex2),
		.hex3(hex3),
		.uart_tx(uart_line),
		.uart_rx(uart_line));

	always #4 core_clk = ~core_clk;

	always @(posedge core_clk)
	begin
		cycles <= cycles + 1;
		if (cycles == cycle_limit)
		begin
			$display("Timeout after %0d cycles, the DUT never answered", cycles);
			$display("Testbench failed");
			$fatal(1);
		end
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		return {1'b0, state[31:1]} ^ (state[0] ? 32'h8020_0003 : 32'h0);	// Galois taps
	endfunction

	task automatic random_byte(output uart_byte_t value);
		for (int i = 0; i < 8; i++)
		begin
			value[i] = lfsr[0];
			lfsr = lfsr_next(lfsr);	// One step per bit
		end
	endtask

	task automatic compare_value(input string name, input io_data_t actual,
		input io_data_t expected);
		assert (actual === expected)
		else
		begin
			$display("[FAIL] %0t %s: got %h, expected %h", $time, name, actual, expected);
			$display("Testbench failed");
			$fatal(1);
		end
	endtask

	task automatic add_step(input int op, input io_addr_t addr, input io_data_t data,
		input io_data_t expected);
		step_t s;
		s.op = op;
		s.addr = addr;
		s.data = data;
		s.expected = expected;
		steps.push_back(s);
	endtask

	// Leaves 1 unit after a rising edge
	task automatic wait_cycles(input int n);
		repeat (n)
		begin
			@(posedge core_clk);
			#1;
		end
	endtask

	task automatic write_reg(input io_addr_t addr, input io_data_t data);
		address = addr;
		write_data = data;
		write_en = 1'b1;
		wait_cycles(1);	// Write edge
		write_en = 1'b0;
	endtask

	task automatic read_reg(input io_addr_t addr, input logic side_effect,
		output io_data_t data);
		address = addr;
		read_en = side_effect;
		#5;
		data = read_data;	// Settled well before the edge
		wait_cycles(1);
		read_en = 1'b0;
	endtask

	task automatic read_output(input io_addr_t addr, output string name,
		output io_data_t value);
		case (addr)
			addr_red_led: value = red_led;
			addr_green_led: value = green_led;
			addr_hex0: value = hex0;
			addr_hex1: value = hex1;
			addr_hex2: value = hex2;
			addr_hex3: value = hex3;
			default: value = '0;	// No output behind it
		endcase
		case (addr)
			addr_red_led: name = "red_led";
			addr_green_led: name = "green_led";
			addr_hex0: name = "hex0";
			addr_hex1: name = "hex1";
			addr_hex2: name = "hex2";
			addr_hex3: name = "hex3";
			default: name = "unmapped";
		endcase
	endtask

	// Polls status without side effects
	task automatic wait_status(input int bit_pos, input logic level);
		io_data_t status;
		read_reg(addr_uart_status, 1'b0, status);
		while (status[bit_pos] !== level)
			read_reg(addr_uart_status, 1'b0, status);
	endtask

	task automatic send_byte(input uart_byte_t value);
		wait_status(status_tx_busy, 1'b0);
		write_reg(addr_uart_tx_data, io_data_t'(value));
		sent.push_back(value);
	endtask

	task automatic read_back(input int count);
		io_data_t value;
		repeat (count)
		begin
			read_reg(addr_uart_rx_data, 1'b1, value);	// Pops FIFO
			compare_value("rx_data", value, io_data_t'(sent.pop_front()));
		end
	endtask

	initial
	begin
		io_data_t value;
		io_data_t first;
		string name;
		uart_byte_t tx_byte;
		logic [9:0] frame;	// Stop, data, start

		add_step(op_read, addr_uart_status, '0, '0);	// Idle UART
		add_step(op_read, 32'd40, '0, '0);	// First word past the map
		add_step(op_read, 32'hffff_fffc, '0, '0);
		add_step(op_write, addr_red_led, 32'h8765_4321, 32'h1_4321);	// 18 bits kept
		add_step(op_write, addr_green_led, 32'hffff_ffff, 32'h1ff);
		add_step(op_write, addr_hex0, 32'hffff_ff80, 32'h00);	// Bit 7 cut off
		add_step(op_write, addr_hex1, 32'h0000_007f, 32'h7f);
		add_step(op_write, addr_hex2, 32'h1234_5655, 32'h55);
		add_step(op_write, addr_hex3, 32'hdead_beef, 32'h6f);
		add_step(op_ignored, 32'd44, 32'h0000_0000, '0);	// Unmapped
		add_step(op_ignored, 32'd2, 32'h0000_0000, '0);	// Misaligned
		add_step(op_output, addr_red_led, '0, 32'h1_4321);	// All unchanged
		add_step(op_output, addr_green_led, '0, 32'h1ff);
		add_step(op_output, addr_hex0, '0, 32'h00);
		add_step(op_output, addr_hex1, '0, 32'h7f);
		add_step(op_output, addr_hex2, '0, 32'h55);
		add_step(op_output, addr_hex3, '0, 32'h6f);
		add_step(op_timer, addr_timer, 32'd1, 32'd1);
		add_step(op_timer, addr_timer, 32'd9, 32'd9);
		add_step(op_timer, addr_timer, 32'd60, 32'd60);

		wait_cycles(10);
		core_reset = 1'b0;
		compare_value("red_led, green_led", {red_led, green_led}, '0);
		compare_value("hex3..hex0", {hex3, hex2, hex1, hex0}, '0);
		compare_value("uart_tx", uart_line, 1'b1);	// Idle line

		foreach (steps[i])
		begin
			case (steps[i].op)
				op_write:
				begin
					write_reg(steps[i].addr, steps[i].data);
					read_output(steps[i].addr, name, value);
					compare_value(name, value, steps[i].expected);
				end
				op_read:
				begin
					read_reg(steps[i].addr, 1'b1, value);
					compare_value("read_data", value, steps[i].expected);
				end
				op_output:
				begin
					read_output(steps[i].addr, name, value);
					compare_value(name, value, steps[i].expected);
				end
				op_ignored:
					write_reg(steps[i].addr, steps[i].data);	// Outputs checked later
				default:
				begin
					read_reg(addr_timer, 1'b0, first);
					wait_cycles(int'(steps[i].data) - 1);	// Read itself takes one
					read_reg(addr_timer, 1'b0, value);
					compare_value("timer delta", value - first, steps[i].expected);
				end
			endcase
		end

		// One frame, sampled at bit centers
		random_byte(tx_byte);
		frame = {1'b1, tx_byte, 1'b0};
		send_byte(tx_byte);
		wait_cycles(baud_divide / 2);
		for (int b = 0; b < 10; b++)
		begin
			compare_value("uart_tx", uart_line, frame[b]);
			if (b == 0)
			begin
				write_reg(addr_uart_tx_data, io_data_t'(~tx_byte));	// Busy, dropped
				read_reg(addr_uart_status, 1'b0, value);
				compare_value("status tx_busy", value[status_tx_busy], 1'b1);
				wait_cycles(baud_divide - 2);
			end
			else
				wait_cycles(baud_divide);
		end
		read_reg(addr_uart_status, 1'b0, value);	// Frame over, none queued behind it
		compare_value("status", value, 1 << status_rx_avail);
		compare_value("uart_tx", uart_line, 1'b1);	// Idle line
		read_back(1);	// Looped back byte
		read_reg(addr_uart_status, 1'b0, value);
		compare_value("status", value, '0);

		// Loopback of three bytes
		repeat (3)
		begin
			random_byte(tx_byte);
			send_byte(tx_byte);
		end
		wait_status(status_tx_busy, 1'b0);
		wait_status(status_rx_avail, 1'b1);
		read_back(3);
		read_reg(addr_uart_status, 1'b0, value);
		compare_value("status rx_avail", value[status_rx_avail], 1'b0);

		// Nine bytes into an eight-entry FIFO
		repeat (9)
		begin
			random_byte(tx_byte);
			send_byte(tx_byte);
		end
		wait_status(status_tx_busy, 1'b0);
		read_reg(addr_uart_status, 1'b1, value);	// Clears overrun
		compare_value("status", value, (1 << status_rx_avail) | (1 << status_overrun));
		read_back(8);
		sent.delete();	// Ninth byte was lost
		read_reg(addr_uart_status, 1'b1, value);
		compare_value("status", value, '0);

		$display("Testbench passed");
		$finish;
	end

endmodule

// ==== io_top.f ====
design/io_pkg.sv
design/uart_pkg.sv
design/uart_if.sv
design/uart_transmit.sv
design/uart_receive.sv
design/uart_rx_fifo.sv
design/io_register_file.sv
design/io_top.sv
sim/io_top_tb.sv

// ==== Bender.yml ====
package:
  name: io_top

sources:
  - design/io_pkg.sv
  - design/uart_pkg.sv
  - design/uart_if.sv
  - design/uart_transmit.sv
  - design/uart_receive.sv
  - design/uart_rx_fifo.sv
  - design/io_register_file.sv
  - design/io_top.sv
  - target: simulation
    files:
      - sim/io_top_tb.sv
